// File: hw/ipod_consts.svh
`ifndef IPOD_CONSTS_SVH
`define IPOD_CONSTS_SVH

// ==============================
// Sample period limits
// ==============================

// About 44 kHz from the 50 MHz clock
`define RATE_DEFAULT 1136
`define RATE_STEP 8
`define RATE_MIN 256
`define RATE_MAX 4096

// Held speed key repeats ten times a second
`define REPEAT_CYCLES 5000000

// Last word address of the stored song
`define SONG_LAST_ADDR 23'h7FFFF

// ==============================
// Keyboard commands, upper case
// ==============================
`define KEY_E 8'h45
`define KEY_D 8'h44
`define KEY_F 8'h46
`define KEY_B 8'h42
`define KEY_R 8'h52

`endif

// File: hw/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // Sample period in CLK_50M cycles
  typedef logic [23:0] rate_count_t;

  // Word address into the song flash
  typedef logic [22:0] flash_addr_t;

  // One signed audio sample
  typedef logic signed [15:0] sample_t;

  // Two samples packed in one flash word, hi in the upper half
  typedef struct packed {
    sample_t hi;
    sample_t lo;
  } sample_pair_t;

  // Flash word as the bus returns it, or as the two samples it holds
  typedef union packed {
    logic [31:0]  raw;
    sample_pair_t pair;
  } flash_word_u;

  // Segment lines of one digit, active low, bit 0 is segment a
  typedef logic [6:0] seg7_t;

endpackage

`default_nettype wire

// File: hw/fetch_if.sv
`default_nettype none
`timescale 1ns/1ps

interface fetch_if;
  import ipod_pkg::*;

  // Request from the player, one cycle wide, only while ready is high
  logic        req;
  flash_addr_t addr;

  // Returned word, held until the next request
  flash_word_u word;
  logic        ready;

  modport player (
    output req,
    output addr,
    input  word,
    input  ready
  );

  modport reader (
    input  req,
    input  addr,
    output word,
    output ready
  );

endinterface

`default_nettype wire

// File: hw/rate_ctrl.sv
`default_nettype none
`timescale 1ns/1ps
`include "ipod_consts.svh"

module rate_ctrl (
  input  wire                   CLK_50M,
  input  wire                   rst_n,
  input  wire                   speed_up,
  input  wire                   speed_down,
  input  wire                   speed_reset,
  output ipod_pkg::rate_count_t count,
  output logic                  tick
);
  import ipod_pkg::*;

  localparam rate_count_t R_DEF  = rate_count_t'(`RATE_DEFAULT);
  localparam rate_count_t R_STEP = rate_count_t'(`RATE_STEP);
  localparam rate_count_t R_MIN  = rate_count_t'(`RATE_MIN);
  localparam rate_count_t R_MAX  = rate_count_t'(`RATE_MAX);
  localparam int REP_W = $clog2(`REPEAT_CYCLES);
  localparam logic [REP_W-1:0] REP_LAST = REP_W'(`REPEAT_CYCLES - 1);

  logic             up_q;
  logic             down_q;
  logic             up_edge;
  logic             down_edge;
  logic [REP_W-1:0] rep_cnt;
  logic             rep_fire;
  logic             step_up;
  logic             step_down;
  rate_count_t      cyc_cnt;

  // ==============================
  // Speed keys and repeat timer
  // ==============================
  assign up_edge   = speed_up & ~up_q;
  assign down_edge = speed_down & ~down_q;
  assign rep_fire  = (rep_cnt == REP_LAST);

  // Shorter period means faster playback
  assign step_up   = up_edge | (speed_up & rep_fire);
  assign step_down = down_edge | (speed_down & rep_fire);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      up_q    <= 1'b0;
      down_q  <= 1'b0;
      rep_cnt <= '0;
    end
    else
    begin
      up_q   <= speed_up;
      down_q <= speed_down;
      // Restart on a fresh press, after each repeat, and on release
      if (up_edge || down_edge || rep_fire || !(speed_up || speed_down))
        rep_cnt <= '0;
      else
        rep_cnt <= rep_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || speed_reset)
      count <= R_DEF;
    else if (step_up)
      count <= (count < R_MIN + R_STEP) ? R_MIN : count - R_STEP;
    else if (step_down)
      count <= (count > R_MAX - R_STEP) ? R_MAX : count + R_STEP;
  end

  // ==============================
  // Sample tick
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      cyc_cnt <= '0;
      tick    <= 1'b0;
    end
    else if (cyc_cnt >= count - 1'b1)
    begin
      // Compare with >= so a shrinking count does not overrun
      cyc_cnt <= '0;
      tick    <= 1'b1;
    end
    else
    begin
      cyc_cnt <= cyc_cnt + 1'b1;
      tick    <= 1'b0;
    end
  end

  a_count_range: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (count >= R_MIN) && (count <= R_MAX))
    else $error("rate count %0d outside limits", count);

endmodule

`default_nettype wire

// File: hw/kbd_command.sv
`default_nettype none
`timescale 1ns/1ps
`include "ipod_consts.svh"

module kbd_command (
  input  wire       CLK_50M,
  input  wire       rst_n,
  input  wire [7:0] kbd_ascii,
  input  wire       kbd_strobe,
  output logic      playing,
  output logic      reverse,
  output logic      restart
);

  logic [7:0] key_up;

  // Clearing bit 5 folds lower-case letters onto upper case
  assign key_up = kbd_ascii & 8'hDF;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      playing <= 1'b0;
      reverse <= 1'b0;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (kbd_strobe)
      begin
        case (key_up)
          `KEY_E: playing <= 1'b1;
          `KEY_D: playing <= 1'b0;
          `KEY_F: reverse <= 1'b0;
          `KEY_B: reverse <= 1'b1;
          // Single-cycle pulse back to the song start
          `KEY_R: restart <= 1'b1;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/flash_reader.sv
`default_nettype none
`timescale 1ns/1ps

module flash_reader (
  input  wire                   CLK_50M,
  input  wire                   rst_n,
  fetch_if.reader               fetch,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output ipod_pkg::flash_addr_t wb_adr,
  input  wire [31:0]            wb_dat_r,
  input  wire                   wb_ack
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_t;

  state_t state;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else
    begin
      case (state)
        ST_IDLE: if (fetch.req) state <= ST_BUSY;
        ST_BUSY: if (wb_ack) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address held for the whole cycle, data caught on ack
  always_ff @(posedge CLK_50M)
  begin
    if (state == ST_IDLE && fetch.req)
      wb_adr <= fetch.addr;
    if (state == ST_BUSY && wb_ack)
      fetch.word.raw <= wb_dat_r;
  end

  // Classic cycle, one strobe per request
  assign wb_cyc      = (state == ST_BUSY);
  assign wb_stb      = (state == ST_BUSY);
  assign fetch.ready = (state == ST_IDLE);

  // The player may only ask for a word while no read is open
  a_req_when_idle: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    fetch.req |-> (state == ST_IDLE))
    else $error("fetch request while a flash read is open");

  a_hold_to_ack: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
    else $error("wishbone stb or adr changed before ack");

endmodule

`default_nettype wire

// File: hw/song_player.sv
`default_nettype none
`timescale 1ns/1ps
`include "ipod_consts.svh"

module song_player (
  input  wire               CLK_50M,
  input  wire               rst_n,
  input  wire               tick,
  input  wire               playing,
  input  wire               reverse,
  input  wire               restart,
  fetch_if.player           fetch,
  output ipod_pkg::sample_t sample,
  output logic              sample_strobe
);
  import ipod_pkg::*;

  localparam flash_addr_t LAST_ADDR = `SONG_LAST_ADDR;

  flash_addr_t addr;
  logic        half;        // 0 selects lo, 1 selects hi
  logic        pending;
  logic        fetch_due;
  logic        rev_q;
  logic        dir_flip;
  logic        word_ok;
  logic        go;
  flash_addr_t step_addr;
  logic        step_cross;

  // ==============================
  // Next position
  // ==============================
  // Forward runs lo then hi, backward hi then lo; the half always toggles
  always_comb
  begin
    step_addr  = addr;
    step_cross = 1'b0;
    if (!reverse && half)
    begin
      step_addr  = (addr == LAST_ADDR) ? '0 : addr + 1'b1;
      step_cross = 1'b1;
    end
    else if (reverse && !half)
    begin
      step_addr  = (addr == '0) ? LAST_ADDR : addr - 1'b1;
      step_cross = 1'b1;
    end
  end

  // A direction change moves one sample the new way, so play resumes
  // from the sample before the current point
  assign dir_flip = reverse ^ rev_q;
  assign word_ok  = fetch.ready & ~fetch_due;
  assign go       = playing & (tick | pending) & word_ok & ~dir_flip;

  // No bus traffic while stopped
  assign fetch.req  = fetch_due & fetch.ready & playing;
  assign fetch.addr = addr;

  // ==============================
  // Position and tick bookkeeping
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      addr          <= '0;
      half          <= 1'b0;
      pending       <= 1'b0;
      fetch_due     <= 1'b1;
      rev_q         <= 1'b0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      rev_q         <= reverse;
      sample_strobe <= go & ~restart;
      if (fetch.req)
        fetch_due <= 1'b0;
      if (restart)
      begin
        addr      <= '0;
        half      <= reverse;
        fetch_due <= 1'b1;
        pending   <= 1'b0;
      end
      else if (go || dir_flip)
      begin
        addr <= step_addr;
        half <= ~half;
        // Word used up, fetch the next one while this sample goes out
        if (step_cross)
          fetch_due <= 1'b1;
        pending <= ~go & playing & (pending | tick);
      end
      else if (playing && tick)
        pending <= 1'b1;
      else if (!playing)
        pending <= 1'b0;
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (go)
      sample <= half ? fetch.word.pair.hi : fetch.word.pair.lo;
  end

  a_strobe_playing: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_strobe |-> $past(playing))
    else $error("sample strobe while playback stopped");

endmodule

`default_nettype wire

// File: hw/hex_display.sv
`default_nettype none
`timescale 1ns/1ps

module hex_display (
  input  wire                   CLK_50M,
  input  wire                   rst_n,
  input  wire ipod_pkg::rate_count_t count,
  output ipod_pkg::seg7_t       hex0,
  output ipod_pkg::seg7_t       hex1,
  output ipod_pkg::seg7_t       hex2,
  output ipod_pkg::seg7_t       hex3,
  output ipod_pkg::seg7_t       hex4,
  output ipod_pkg::seg7_t       hex5
);
  import ipod_pkg::*;

  rate_count_t count_q;

  // Segment order gfedcba, a zero lights the segment
  function automatic seg7_t digit_seg(input logic [3:0] d);
    case (d)
      4'h0: digit_seg = 7'h40;
      4'h1: digit_seg = 7'h79;
      4'h2: digit_seg = 7'h24;
      4'h3: digit_seg = 7'h30;
      4'h4: digit_seg = 7'h19;
      4'h5: digit_seg = 7'h12;
      4'h6: digit_seg = 7'h02;
      4'h7: digit_seg = 7'h78;
      4'h8: digit_seg = 7'h00;
      4'h9: digit_seg = 7'h10;
      4'hA: digit_seg = 7'h08;
      4'hB: digit_seg = 7'h03;
      4'hC: digit_seg = 7'h46;
      4'hD: digit_seg = 7'h21;
      4'hE: digit_seg = 7'h06;
      default: digit_seg = 7'h0E;
    endcase
  endfunction

  // Two stages, count then segments
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      count_q <= '0;
      hex0    <= '1;
      hex1    <= '1;
      hex2    <= '1;
      hex3    <= '1;
      hex4    <= '1;
      hex5    <= '1;
    end
    else
    begin
      count_q <= count;
      hex0    <= digit_seg(count_q[3:0]);
      hex1    <= digit_seg(count_q[7:4]);
      hex2    <= digit_seg(count_q[11:8]);
      hex3    <= digit_seg(count_q[15:12]);
      hex4    <= digit_seg(count_q[19:16]);
      hex5    <= digit_seg(count_q[23:20]);
    end
  end

endmodule

`default_nettype wire

// File: hw/ipod_top.sv
`default_nettype none
`timescale 1ns/1ps

module ipod_top (
  input  wire         CLK_50M,
  input  wire         rst_n,
  input  wire  [7:0]  kbd_ascii,
  input  wire         kbd_strobe,
  input  wire         speed_up,
  input  wire         speed_down,
  input  wire         speed_reset,
  input  wire  [31:0] wb_dat_r,
  input  wire         wb_ack,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic [22:0] wb_adr,
  output logic [15:0] sample,
  output logic        sample_strobe,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);
  import ipod_pkg::*;

  rate_count_t count;
  logic        tick;
  logic        playing;
  logic        reverse;
  logic        restart;

  fetch_if fetch ();

  // ==============================
  // Control
  // ==============================
  rate_ctrl u_rate_ctrl (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .count       (count),
    .tick        (tick)
  );

  kbd_command u_kbd_command (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .kbd_ascii  (kbd_ascii),
    .kbd_strobe (kbd_strobe),
    .playing    (playing),
    .reverse    (reverse),
    .restart    (restart)
  );

  // ==============================
  // Playback path
  // ==============================
  song_player u_song_player (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .tick          (tick),
    .playing       (playing),
    .reverse       (reverse),
    .restart       (restart),
    .fetch         (fetch.player),
    .sample        (sample),
    .sample_strobe (sample_strobe)
  );

  flash_reader u_flash_reader (
    .CLK_50M  (CLK_50M),
    .rst_n    (rst_n),
    .fetch    (fetch.reader),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_adr   (wb_adr),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  // Period count on the six digits
  hex_display u_hex_display (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .count   (count),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK_50M,
  output logic rst_n
);

  // 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Reset held for 8 cycles, released on a falling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (8) @(posedge CLK_50M);
    @(negedge CLK_50M);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_ipod.sv
`default_nettype none
`timescale 1ns/1ps
`include "ipod_consts.svh"

module tb_ipod;

  localparam logic [2:0] K_IDLE  = 3'd0;
  localparam logic [2:0] K_SPEED = 3'd1;
  localparam logic [2:0] K_KEY   = 3'd2;
  localparam logic [2:0] K_QUIET = 3'd3;
  localparam logic [2:0] K_PLAY  = 3'd4;

  localparam logic [7:0] SPD_UP    = 8'd1;
  localparam logic [7:0] SPD_DOWN  = 8'd2;
  localparam logic [7:0] SPD_RESET = 8'd3;

  localparam logic [22:0] LAST_ADDR = `SONG_LAST_ADDR;

  // One row of the command table
  typedef struct packed {
    logic [2:0]  kind;
    logic [7:0]  code;
    logic [15:0] n;     // samples or cycles to observe
    logic [22:0] addr;  // first sample position
    logic        hi;
    logic        back;
    logic [23:0] rate;  // expected period on the display
  } row_t;

  wire         CLK_50M;
  wire         rst_n;
  logic [7:0]  kbd_ascii;
  logic        kbd_strobe;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  wire         wb_cyc;
  wire         wb_stb;
  wire  [22:0] wb_adr;
  wire  [15:0] sample;
  wire         sample_strobe;
  wire  [6:0]  hex0;
  wire  [6:0]  hex1;
  wire  [6:0]  hex2;
  wire  [6:0]  hex3;
  wire  [6:0]  hex4;
  wire  [6:0]  hex5;
  wire  [41:0] hex_all;

  row_t          rows [0:15];
  int            n_rows;
  logic [15:0]   seen [$];
  int            cyc_cycles;
  int            tests_run;
  int            tests_failed;
  int            errors;
  longint        limit_ns;
  logic          table_ready;

  assign hex_all = {hex5, hex4, hex3, hex2, hex1, hex0};

  tb_clock_gen u_clock_gen (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n)
  );

  ipod_top UUT (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .kbd_ascii     (kbd_ascii),
    .kbd_strobe    (kbd_strobe),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_adr        (wb_adr),
    .sample        (sample),
    .sample_strobe (sample_strobe),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

  // ==============================
  // Reference rules
  // ==============================
  // Flash hi half is the address XOR 5A5A and lo half the address
  function automatic logic [31:0] flash_word(input logic [22:0] a);
    return {a[15:0] ^ 16'h5A5A, a[15:0]};
  endfunction

  function automatic logic [15:0] half_of(input logic [22:0] a, input logic hi);
    logic [31:0] w;
    w = flash_word(a);
    return hi ? w[31:16] : w[15:0];
  endfunction

  // Forward goes lo then hi, backward hi then lo, both wrap
  task automatic advance_position(inout logic [22:0] a, inout logic hi, input logic back);
    if (!back && hi)
      a = (a == LAST_ADDR) ? 23'd0 : a + 23'd1;
    else if (back && !hi)
      a = (a == 23'd0) ? LAST_ADDR : a - 23'd1;
    hi = ~hi;
  endtask

  // Standard hex digits, gfedcba with one meaning lit, inverted for the board
  function automatic logic [6:0] digit_segments(input logic [3:0] d);
    logic [6:0] lit;
    case (d)
      4'h0: lit = 7'b0111111;
      4'h1: lit = 7'b0000110;
      4'h2: lit = 7'b1011011;
      4'h3: lit = 7'b1001111;
      4'h4: lit = 7'b1100110;
      4'h5: lit = 7'b1101101;
      4'h6: lit = 7'b1111101;
      4'h7: lit = 7'b0000111;
      4'h8: lit = 7'b1111111;
      4'h9: lit = 7'b1101111;
      4'hA: lit = 7'b1110111;
      4'hB: lit = 7'b1111100;
      4'hC: lit = 7'b0111001;
      4'hD: lit = 7'b1011110;
      4'hE: lit = 7'b1111001;
      default: lit = 7'b1110001;
    endcase
    return ~lit;
  endfunction

  function automatic string kind_name(input logic [2:0] kind);
    case (kind)
      K_IDLE:  return "idle after reset";
      K_SPEED: return "speed key";
      K_KEY:   return "command";
      K_QUIET: return "stopped";
      default: return "playback";
    endcase
  endfunction

  // ==============================
  // Flash model and monitor
  // ==============================
  initial
  begin
    int ack_wait;
    void'($urandom(32'h862a));
    ack_wait = 0;
    wb_ack   = 1'b0;
    wb_dat_r = '0;
    forever
    begin
      @(negedge CLK_50M);
      if (rst_n !== 1'b1 || wb_ack)
      begin
        wb_ack   = 1'b0;
        ack_wait = 0;
      end
      else if (wb_cyc && wb_stb)
      begin
        // Ack after 1 to 4 cycles
        if (ack_wait == 0)
          ack_wait = int'($urandom % 4) + 1;
        ack_wait = ack_wait - 1;
        if (ack_wait == 0)
        begin
          wb_dat_r = flash_word(wb_adr);
          wb_ack   = 1'b1;
        end
      end
    end
  end

  always @(negedge CLK_50M)
  begin
    if (rst_n === 1'b1)
    begin
      if (sample_strobe)
        seen.push_back(sample);
      if (wb_cyc || wb_stb)
        cyc_cycles = cyc_cycles + 1;
    end
  end

  // ==============================
  // Stimulus and checks
  // ==============================
  task automatic add_row(input logic [2:0] kind, input logic [7:0] code, input int n,
                         input logic [22:0] addr, input logic hi, input logic back,
                         input int rate);
    rows[n_rows].kind = kind;
    rows[n_rows].code = code;
    rows[n_rows].n    = 16'(n);
    rows[n_rows].addr = addr;
    rows[n_rows].hi   = hi;
    rows[n_rows].back = back;
    rows[n_rows].rate = 24'(rate);
    n_rows = n_rows + 1;
  endtask

  task automatic build_table();
    n_rows = 0;
    add_row(K_IDLE, 8'h00, 3000, 23'd0, 1'b0, 1'b0, `RATE_DEFAULT);
    add_row(K_SPEED, SPD_UP, 6, 23'd0, 1'b0, 1'b0, `RATE_DEFAULT - `RATE_STEP);
    add_row(K_SPEED, SPD_DOWN, 6, 23'd0, 1'b0, 1'b0, `RATE_DEFAULT);
    add_row(K_SPEED, SPD_UP, 6, 23'd0, 1'b0, 1'b0, `RATE_DEFAULT - `RATE_STEP);
    add_row(K_SPEED, SPD_RESET, 6, 23'd0, 1'b0, 1'b0, `RATE_DEFAULT);
    add_row(K_PLAY, `KEY_E, 8, 23'd0, 1'b0, 1'b0, `RATE_DEFAULT);
    // Last forward sample was 3 hi, lower-case b resumes there going back
    add_row(K_PLAY, `KEY_B | 8'h20, 6, 23'd3, 1'b1, 1'b1, `RATE_DEFAULT);
    add_row(K_QUIET, `KEY_D, 5000, 23'd0, 1'b0, 1'b0, `RATE_DEFAULT);
    add_row(K_KEY, `KEY_R, 0, 23'd0, 1'b0, 1'b0, `RATE_DEFAULT);
    add_row(K_KEY, `KEY_F | 8'h20, 0, 23'd0, 1'b0, 1'b0, `RATE_DEFAULT);
    // Restart while backward sits on 0 hi; turning forward steps one sample on
    add_row(K_PLAY, `KEY_E, 6, 23'd1, 1'b0, 1'b0, `RATE_DEFAULT);
    add_row(K_KEY, `KEY_R, 0, 23'd0, 1'b0, 1'b0, `RATE_DEFAULT);
    add_row(K_KEY, `KEY_B, 0, 23'd0, 1'b0, 1'b0, `RATE_DEFAULT);
    add_row(K_PLAY, `KEY_E, 4, LAST_ADDR, 1'b1, 1'b1, `RATE_DEFAULT);
  endtask

  task automatic send_key(input logic [7:0] code);
    @(negedge CLK_50M);
    kbd_ascii  = code;
    kbd_strobe = 1'b1;
    @(negedge CLK_50M);
    kbd_strobe = 1'b0;
  endtask

  task automatic press_speed(input logic [7:0] code);
    @(negedge CLK_50M);
    speed_up    = (code == SPD_UP);
    speed_down  = (code == SPD_DOWN);
    speed_reset = (code == SPD_RESET);
    @(negedge CLK_50M);
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
  endtask

  // Capture is cleared on the rising edge, the monitor works on the falling one
  task automatic clear_capture();
    @(posedge CLK_50M);
    seen.delete();
    cyc_cycles = 0;
  endtask

  task automatic check_display(input int r, inout bit ok);
    int         i;
    logic [6:0] want;
    @(negedge CLK_50M);
    for (i = 0; i < 6; i++)
    begin
      want = digit_segments(rows[r].rate[4*i +: 4]);
      if (hex_all[7*i +: 7] !== want)
      begin
        $display("mismatch at %0t: row %0d hex%0d is %h, expected %h for count %0d",
                 $time, r, i, hex_all[7*i +: 7], want, rows[r].rate);
        errors = errors + 1;
        ok = 1'b0;
      end
    end
  endtask

  task automatic check_quiet(input int r, input bit with_bus, inout bit ok);
    repeat (rows[r].n) @(negedge CLK_50M);
    @(posedge CLK_50M);
    if (seen.size() != 0)
    begin
      $display("row %0d: %0d samples came out while playback was stopped", r, seen.size());
      errors = errors + 1;
      ok = 1'b0;
    end
    if (with_bus && cyc_cycles != 0)
    begin
      $display("row %0d: a flash read started before playback was enabled", r);
      errors = errors + 1;
      ok = 1'b0;
    end
  endtask

  task automatic check_samples(input int r, inout bit ok);
    int          waited;
    int          i;
    logic [22:0] a;
    logic        hi;
    logic [15:0] want;
    a = rows[r].addr;
    hi = rows[r].hi;
    waited = 0;
    while (seen.size() < int'(rows[r].n) && waited < int'(rows[r].n) * 2 * `RATE_MAX)
    begin
      @(posedge CLK_50M);
      waited = waited + 1;
    end
    if (seen.size() < int'(rows[r].n))
    begin
      $display("row %0d: only %0d of %0d samples arrived in time", r, seen.size(), rows[r].n);
      errors = errors + 1;
      ok = 1'b0;
    end
    else
    begin
      for (i = 0; i < int'(rows[r].n); i++)
      begin
        want = half_of(a, hi);
        if (seen[i] !== want)
        begin
          $display("mismatch at %0t: row %0d sample %0d of word %h %s is %h, expected %h",
                   $time, r, i, a, hi ? "hi" : "lo", seen[i], want);
          errors = errors + 1;
          ok = 1'b0;
        end
        advance_position(a, hi, rows[r].back);
      end
    end
  endtask

  task automatic run_row(input int r, inout bit ok);
    case (rows[r].kind)
      K_IDLE:
      begin
        clear_capture();
        check_quiet(r, 1'b1, ok);
        check_display(r, ok);
      end
      K_SPEED:
      begin
        press_speed(rows[r].code);
        repeat (rows[r].n) @(negedge CLK_50M);
        check_display(r, ok);
      end
      K_QUIET:
      begin
        clear_capture();
        send_key(rows[r].code);
        check_quiet(r, 1'b0, ok);
      end
      K_PLAY:
      begin
        clear_capture();
        send_key(rows[r].code);
        check_samples(r, ok);
      end
      default: send_key(rows[r].code);
    endcase
  endtask

  // Watchdog sized at twice the slowest playback time plus a margin
  initial
  begin
    wait (table_ready === 1'b1);
    #(limit_ns);
    $display("Timeout: the run did not finish within %0d ns", limit_ns);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    int r;
    int total;
    bit ok;
    table_ready  = 1'b0;
    kbd_ascii    = 8'h00;
    kbd_strobe   = 1'b0;
    speed_up     = 1'b0;
    speed_down   = 1'b0;
    speed_reset  = 1'b0;
    cyc_cycles   = 0;
    tests_run    = 0;
    tests_failed = 0;
    errors       = 0;
    build_table();
    total = 0;
    for (r = 0; r < n_rows; r++)
    begin
      if (rows[r].kind == K_PLAY)
        total = total + int'(rows[r].n);
    end
    limit_ns = 2 * longint'(total) * `RATE_MAX * 20 + 1000000;
    table_ready = 1'b1;

    wait (rst_n === 1'b1);
    for (r = 0; r < n_rows; r++)
    begin
      ok = 1'b1;
      run_row(r, ok);
      tests_run = tests_run + 1;
      if (!ok)
        tests_failed = tests_failed + 1;
      $display("row %0d %s: %s", r, kind_name(rows[r].kind), ok ? "pass" : "fail");
    end

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
hw/ipod_pkg.sv
hw/fetch_if.sv
hw/rate_ctrl.sv
hw/kbd_command.sv
hw/flash_reader.sv
hw/song_player.sv
hw/hex_display.sv
hw/ipod_top.sv
test/tb_clock_gen.sv
test/tb_ipod.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ipod
FILELIST  = files.f

OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Output stays visible on stderr, grep decides the exit status
run: compile
	./$(SIM) | tee /dev/stderr | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
